//--- adc_integrator.sv
// integrator that sums a fixed number of valid samples per measurement request
`timescale 1ns/1ps

module adc_integrator #(
  parameter int APERTURE_N = 16
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic signed [az_pkg::SAMPLE_W-1:0] sample,
  input  logic                               sample_valid,
  meas_if.adc                                meas
);
  import az_pkg::*;

  // counts accepted samples 0 .. APERTURE_N-1
  localparam int CNT_W = $clog2(APERTURE_N + 1);

  logic                    busy;
  logic [CNT_W-1:0]        cnt;
  logic signed [SUM_W-1:0] acc;
  logic signed [SUM_W-1:0] sample_ext;

  // sign extend to the sum width
  assign sample_ext = {{(SUM_W - SAMPLE_W){sample[SAMPLE_W-1]}}, sample};

  // acc is frozen once busy drops, so it is the result while done is high
  assign meas.sum = acc;

  //////////////////////////////
  // control
  //////////////////////////////
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      busy              <= 1'b0;
      cnt               <= '0;
      meas.measure_done <= 1'b0;
    end
    else
    begin
      meas.measure_done <= 1'b0;
      if (meas.take_measure)
      begin
        // new request restarts the aperture
        busy <= 1'b1;
        cnt  <= '0;
      end
      else if (busy && sample_valid)
      begin
        if (cnt == CNT_W'(APERTURE_N - 1))
        begin
          // last sample of the aperture
          busy              <= 1'b0;
          meas.measure_done <= 1'b1;
        end
        cnt <= cnt + 1'b1;
      end
    end
  end

  //////////////////////////////
  // accumulator
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (meas.take_measure)
      acc <= '0;
    else if (busy && sample_valid)
      acc <= acc + sample_ext;
  end

endmodule

//--- az_checker.sv
// concurrent assertions on the switch sequence and output handshake, bound into the front end top
`timescale 1ns/1ps

module az_checker #(
  parameter int PRECHARGE_N = 20
) (
  input logic                             clk,
  input logic                             reset,
  input logic [az_pkg::AZMUX_W-1:0]       azmux_lo_val,
  input logic                             sw_pc_ctl,
  input logic [az_pkg::AZMUX_W-1:0]       azmux,
  input logic signed [az_pkg::SUM_W-1:0]  diff,
  input logic                             diff_valid,
  input logic                             diff_ready,
  input az_pkg::az_state_t                state
);
  import az_pkg::*;

  // age saturates one past the settle length
  localparam int AGE_W   = $clog2(PRECHARGE_N + 3);
  localparam int AGE_MAX = PRECHARGE_N + 1;

  // failed assertions, read by the testbench at the end of the run
  int               fail_cnt = 0;
  // cycles that sw_pc has spent at boot since it last was at signal
  logic [AGE_W-1:0] boot_age;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      boot_age <= AGE_W'(AGE_MAX);
    else if (sw_pc_ctl == SW_PC_SIGNAL)
      boot_age <= '0;
    else if (boot_age != AGE_W'(AGE_MAX))
      boot_age <= boot_age + 1'b1;
  end

  //////////////////////////////
  // switch sequencing
  //////////////////////////////

  // signal path only opens onto the precharge output
  signal_on_hi: assert property (@(posedge clk) disable iff (reset)
    sw_pc_ctl == SW_PC_SIGNAL |-> azmux == AZMUX_HI_SEL)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("sw_pc at signal while azmux is %h", azmux);
  end

  // azmux only moves with sw_pc at boot on both sides of the edge
  azmux_moves_at_boot: assert property (@(posedge clk) disable iff (reset)
    azmux != $past(azmux) |-> sw_pc_ctl == SW_PC_BOOT && $past(sw_pc_ctl) == SW_PC_BOOT)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("azmux changed while sw_pc was at signal");
  end

  // charge injection settles before the mux moves
  settle_before_mux: assert property (@(posedge clk) disable iff (reset)
    azmux != $past(azmux) |-> boot_age > AGE_W'(PRECHARGE_N))
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("azmux changed %0d cycles after sw_pc went to boot", boot_age);
  end

  //////////////////////////////
  // output handshake
  //////////////////////////////

  // word held until ready
  diff_held: assert property (@(posedge clk) disable iff (reset)
    diff_valid && !diff_ready |=> diff_valid && diff == $past(diff))
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("diff dropped or changed under back-pressure");
  end

  // parked at lo with the signal protected while the word waits
  parked_under_backpressure: assert property (@(posedge clk) disable iff (reset)
    diff_valid && !diff_ready |->
      state == SLOT_WAIT && sw_pc_ctl == SW_PC_BOOT && azmux == azmux_lo_val)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("sequencer left its parked position under back-pressure");
  end

endmodule

//--- az_frontend_top.sv
// top level of the auto-zero front end, sets the timing parameters and wires the blocks
`timescale 1ns/1ps

module az_frontend_top #(
  // precharge settle interval in clocks
  parameter int PRECHARGE_N = 20,
  // valid samples per measurement
  parameter int APERTURE_N  = 16
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [az_pkg::AZMUX_W-1:0]         azmux_lo_val,
  input  logic signed [az_pkg::SAMPLE_W-1:0] sample,
  input  logic                               sample_valid,
  output logic                               sw_pc_ctl,
  output logic [az_pkg::AZMUX_W-1:0]         azmux,
  output logic signed [az_pkg::SUM_W-1:0]    diff,
  output logic                               diff_valid,
  input  logic                               diff_ready
);

  // request, phase, done and sum shared by the three blocks
  meas_if u_meas ();

  //////////////////////////////
  // switch sequencing
  //////////////////////////////
  az_sequencer #(
    .PRECHARGE_N (PRECHARGE_N)
  ) u_seq (
    .clk          (clk),
    .reset        (reset),
    .azmux_lo_val (azmux_lo_val),
    .sw_pc_ctl    (sw_pc_ctl),
    .azmux        (azmux),
    .meas         (u_meas.seq)
  );

  //////////////////////////////
  // integration
  //////////////////////////////
  adc_integrator #(
    .APERTURE_N (APERTURE_N)
  ) u_adc (
    .clk          (clk),
    .reset        (reset),
    .sample       (sample),
    .sample_valid (sample_valid),
    .meas         (u_meas.adc)
  );

  // hi minus lo, held until the consumer takes it
  az_result u_res (
    .clk        (clk),
    .reset      (reset),
    .meas       (u_meas.res),
    .diff       (diff),
    .diff_valid (diff_valid),
    .diff_ready (diff_ready)
  );

endmodule

//--- az_pkg.sv
// shared widths, switch levels and sequencer states, imported by every front end block
package az_pkg;

  //////////////////////////////
  // data widths
  //////////////////////////////

  // one digitized sample from the adc
  localparam int SAMPLE_W = 16;

  // integrator sum and auto-zeroed difference, both signed
  localparam int SUM_W = 32;

  // auto-zero mux select
  localparam int AZMUX_W = 4;

  //////////////////////////////
  // switch encodings
  //////////////////////////////

  // azmux code for the precharge output, S1 on the mux
  localparam logic [AZMUX_W-1:0] AZMUX_HI_SEL = 4'b1000;

  // precharge switch levels
  // boot shields the signal from az switch charge injection
  localparam logic SW_PC_BOOT   = 1'b0;
  localparam logic SW_PC_SIGNAL = 1'b1;

  //////////////////////////////
  // sequencer states
  //////////////////////////////

  // each switch change state is followed by its own wait state
  typedef enum logic [3:0] {
    IDLE,
    BOOT,
    BOOT_WAIT,
    HI_SETTLE,
    HI_SETTLE_WAIT,
    HI_MEAS,
    HI_WAIT,
    PROTECT,
    PROTECT_WAIT,
    LO_MEAS,
    LO_WAIT,
    SLOT_WAIT
  } az_state_t;

endpackage

//--- az_result.sv
// result stage that subtracts the lo sum from the hi sum and holds it on a valid/ready port
`timescale 1ns/1ps

module az_result (
  input  logic                             clk,
  input  logic                             reset,
  meas_if.res                              meas,
  output logic signed [az_pkg::SUM_W-1:0]  diff,
  output logic                             diff_valid,
  input  logic                             diff_ready
);
  import az_pkg::*;

  // hi sum waiting for its lo partner
  logic signed [SUM_W-1:0] hi_sum;
  logic                    hi_pending;
  logic                    lo_done;
  logic                    accept;

  assign lo_done = meas.measure_done && !meas.phase_hi && hi_pending;
  assign accept  = diff_valid && diff_ready;

  // room only when nothing is buffered at all
  // sequencer waits on this before the next hi phase
  assign meas.slot_free = !diff_valid && !hi_pending;

  //////////////////////////////
  // occupancy
  //////////////////////////////
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      hi_pending <= 1'b0;
      diff_valid <= 1'b0;
    end
    else
    begin
      if (meas.measure_done && meas.phase_hi)
        hi_pending <= 1'b1;
      else if (lo_done)
        hi_pending <= 1'b0;

      // a new load wins over the transfer of the old word
      if (lo_done)
        diff_valid <= 1'b1;
      else if (accept)
        diff_valid <= 1'b0;
    end
  end

  //////////////////////////////
  // data
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (meas.measure_done && meas.phase_hi)
      hi_sum <= meas.sum;
    // diff only loads on lo_done, so it holds while waiting for ready
    if (lo_done)
      diff <= hi_sum - meas.sum;
  end

endmodule

//--- az_sequencer.sv
// auto-zero sequencer that drives the precharge switch and azmux through hi and lo phases
`timescale 1ns/1ps

module az_sequencer #(
  parameter int PRECHARGE_N = 20
) (
  input  logic                       clk,
  input  logic                       reset,
  // lo input code for the az mux
  input  logic [az_pkg::AZMUX_W-1:0] azmux_lo_val,
  output logic                       sw_pc_ctl,
  output logic [az_pkg::AZMUX_W-1:0] azmux,
  meas_if.seq                        meas
);
  import az_pkg::*;

  // counter has to hold PRECHARGE_N, keep it at least one bit wide
  localparam int CNT_W = $clog2(PRECHARGE_N + 2);

  az_state_t  state;
  logic [CNT_W-1:0] cnt;
  // azmux sits on the precharge output while set
  logic       sel_hi;

  // lo code follows the input directly
  // it only moves while the sequencer is parked with sw_pc at boot
  assign azmux = sel_hi ? AZMUX_HI_SEL : azmux_lo_val;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state             <= IDLE;
      cnt               <= '0;
      sel_hi            <= 1'b0;
      sw_pc_ctl         <= SW_PC_BOOT;
      meas.take_measure <= 1'b0;
      meas.phase_hi     <= 1'b0;
    end
    else
    begin
      // start pulse lasts a single cycle
      meas.take_measure <= 1'b0;

      case (state)
        IDLE:
          state <= BOOT;

        //////////////////////////////
        // boot the precharge switch
        //////////////////////////////
        BOOT:
        begin
          sw_pc_ctl <= SW_PC_BOOT;
          cnt       <= CNT_W'(PRECHARGE_N);
          state     <= BOOT_WAIT;
        end

        BOOT_WAIT:
          if (cnt == '0)
            state <= HI_SETTLE;
          else
            cnt <= cnt - 1'b1;

        //////////////////////////////
        // azmux to pc out, signal still protected
        //////////////////////////////
        HI_SETTLE:
        begin
          sel_hi <= 1'b1;
          cnt    <= CNT_W'(PRECHARGE_N);
          state  <= HI_SETTLE_WAIT;
        end

        HI_SETTLE_WAIT:
          if (cnt == '0)
            state <= HI_MEAS;
          else
            cnt <= cnt - 1'b1;

        // release precharge switch and start hi integration
        HI_MEAS:
        begin
          sw_pc_ctl         <= SW_PC_SIGNAL;
          meas.phase_hi     <= 1'b1;
          meas.take_measure <= 1'b1;
          state             <= HI_WAIT;
        end

        // aperture length varies with sample_valid gaps
        HI_WAIT:
          if (meas.measure_done)
            state <= PROTECT;

        //////////////////////////////
        // back to boot before azmux moves
        //////////////////////////////
        PROTECT:
        begin
          sw_pc_ctl <= SW_PC_BOOT;
          cnt       <= CNT_W'(PRECHARGE_N);
          state     <= PROTECT_WAIT;
        end

        PROTECT_WAIT:
          if (cnt == '0)
            state <= LO_MEAS;
          else
            cnt <= cnt - 1'b1;

        // azmux to lo input and start lo integration
        LO_MEAS:
        begin
          sel_hi            <= 1'b0;
          meas.phase_hi     <= 1'b0;
          meas.take_measure <= 1'b1;
          state             <= LO_WAIT;
        end

        LO_WAIT:
          if (meas.measure_done)
            state <= SLOT_WAIT;

        // hold at lo with pc at boot until the result stage has room
        SLOT_WAIT:
          if (meas.slot_free)
            state <= HI_SETTLE;

        default:
          state <= IDLE;
      endcase
    end
  end

endmodule

//--- meas_if.sv
// measurement handshake between the az sequencer, the integrator and the result stage
`timescale 1ns/1ps

interface meas_if;
  import az_pkg::*;

  // one cycle start pulse from the sequencer
  logic                    take_measure;
  // high for the whole hi measurement, low for lo
  logic                    phase_hi;
  // one cycle end pulse from the integrator
  logic                    measure_done;
  // integrator result, valid with measure_done
  logic signed [SUM_W-1:0] sum;
  // result stage has room for a new hi/lo pair
  logic                    slot_free;

  // sequencer side
  modport seq (
    output take_measure, phase_hi,
    input  measure_done, slot_free
  );

  // integrator side
  modport adc (input take_measure, output measure_done, sum);

  // result stage side
  modport res (
    input  measure_done, phase_hi, sum,
    output slot_free
  );

endinterface

//--- run_sim.sh
#!/bin/sh
# compile and run the front end testbench with verilator, exit status reflects the result

LOG=sim.log
TOP=tb_az_frontend

if ! verilator --binary --assert --timing --top-module "$TOP" \
    -f sim.f --Mdir obj_dir -o "$TOP"; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/"$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  exit 0
fi

echo "pass message not found in $LOG"
exit 1

//--- sim.f
az_pkg.sv
meas_if.sv
az_sequencer.sv
adc_integrator.sv
az_result.sv
az_frontend_top.sv
az_checker.sv
tb_az_frontend.sv

//--- tb_az_frontend.sv
// testbench for the auto-zero front end, drives samples and back-pressure and checks each diff
`timescale 1ns/1ps

module tb_az_frontend;
  import az_pkg::*;

  localparam int PRECHARGE_N      = 20;
  localparam int APERTURE_N       = 16;
  localparam int CLK_PERIOD       = 8;
  localparam int RESET_CYCLES     = 10;
  localparam int NUM_RESULTS      = 30;
  localparam int WATCHDOG_RESULTS = 40;
  // three settle intervals, two apertures with sample gaps, and a ready wait
  localparam int CYCLE_MAX = 3 * (PRECHARGE_N + 2) + 2 * (4 * APERTURE_N + 2) + 64;
  localparam logic [31:0] LFSR_SEED = 32'h4e21435e;
  // x^32 + x^22 + x^2 + x + 1, right shifting
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic                      clk;
  logic                      reset;
  logic [AZMUX_W-1:0]        azmux_lo_val = 4'd3;
  logic signed [SAMPLE_W-1:0] sample      = '0;
  logic                      sample_valid = 1'b0;
  logic                      diff_ready   = 1'b0;
  logic                      sw_pc_ctl;
  logic [AZMUX_W-1:0]        azmux;
  logic signed [SUM_W-1:0]   diff;
  logic                      diff_valid;

  // levels seen by the analog model in the two phases
  logic signed [SAMPLE_W-1:0] hi_level = 16'sd1200;
  logic signed [SAMPLE_W-1:0] lo_level = -16'sd300;

  logic [31:0] lfsr = LFSR_SEED;
  logic [31:0] rnd;
  int          exp_diff;
  int          results      = 0;
  int          data_errors  = 0;
  int          reset_errors = 0;

  az_frontend_top #(
    .PRECHARGE_N (PRECHARGE_N),
    .APERTURE_N  (APERTURE_N)
  ) DUT (
    .clk          (clk),
    .reset        (reset),
    .azmux_lo_val (azmux_lo_val),
    .sample       (sample),
    .sample_valid (sample_valid),
    .sw_pc_ctl    (sw_pc_ctl),
    .azmux        (azmux),
    .diff         (diff),
    .diff_valid   (diff_valid),
    .diff_ready   (diff_ready)
  );

  bind az_frontend_top az_checker #(
    .PRECHARGE_N (PRECHARGE_N)
  ) u_chk (
    .clk          (clk),
    .reset        (reset),
    .azmux_lo_val (azmux_lo_val),
    .sw_pc_ctl    (sw_pc_ctl),
    .azmux        (azmux),
    .diff         (diff),
    .diff_valid   (diff_valid),
    .diff_ready   (diff_ready),
    .state        (u_seq.state)
  );

  //////////////////////////////
  // random bits
  //////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ LFSR_TAPS;
    else
      return s >> 1;
  endfunction

  // one lfsr step per bit, msb first
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // analog model, stimulus and data check
  //////////////////////////////
  always @(posedge clk)
  begin
    if (!reset)
    begin
      sample <= (azmux == AZMUX_HI_SEL) ? hi_level : lo_level;
      // samples valid three cycles in four
      rnd = draw_bits(2);
      sample_valid <= (rnd[1:0] != 2'b00);
      // ready one cycle in four, so words often wait
      rnd = draw_bits(2);
      diff_ready <= (rnd[1:0] == 2'b00);

      if (diff_valid && diff_ready)
      begin
        exp_diff = APERTURE_N * (int'(hi_level) - int'(lo_level));
        assert (diff == exp_diff)
        else
        begin
          data_errors++;
          $display("CHECK FAILED %0t: diff %0d, expected %0d", $time, diff, exp_diff);
        end
        results <= results + 1;
        // sequencer is parked in SLOT_WAIT, safe to move the levels
        rnd = draw_bits(SAMPLE_W);
        hi_level <= rnd[SAMPLE_W-1:0];
        rnd = draw_bits(SAMPLE_W);
        lo_level <= rnd[SAMPLE_W-1:0];
        // msb clear keeps the lo code off the precharge select
        rnd = draw_bits(AZMUX_W - 1);
        azmux_lo_val <= {1'b0, rnd[AZMUX_W-2:0]};
      end
    end
  end

  //////////////////////////////
  // reset, end of run
  //////////////////////////////
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    @(negedge clk);
    assert (sw_pc_ctl == SW_PC_BOOT && !diff_valid && azmux == azmux_lo_val)
    else
    begin
      reset_errors++;
      $display("CHECK FAILED %0t: after reset sw_pc_ctl %b diff_valid %b azmux %h",
               $time, sw_pc_ctl, diff_valid, azmux);
    end

    wait (results == NUM_RESULTS);
    @(negedge clk);
    $display("errors: %0d after reset, %0d on data, %0d in checker",
             reset_errors, data_errors, DUT.u_chk.fail_cnt);
    if (reset_errors + data_errors + DUT.u_chk.fail_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_RESULTS * CYCLE_MAX * CLK_PERIOD);
    $display("timeout: only %0d of %0d results were accepted", results, NUM_RESULTS);
    $display("TB FAILED");
    $finish;
  end

endmodule
